//--- compile.f
edge_pkg.sv
fifo.sv
non_maximum_suppressor.sv
edge_threshold.sv
edge_stage_top.sv
edge_checker.sv
edge_tb.sv

//--- edge_checker.sv
module edge_checker
    import edge_pkg::*;
#(
    parameter int reduced_width  = 8,
    parameter int reduced_height = 6,
    parameter int width          = 10,
    parameter int height         = 8,
    parameter int starting_x     = 0,
    parameter int starting_y     = 1,
    parameter int low_threshold  = 40,
    parameter int high_threshold = 120
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        in_wr_en,
    input  pixel_t      in_din,
    input  logic        out_rd_en,
    input  edge_class_t out_dout,
    output int          written,
    output int          popped,
    output int          mismatches
);

    localparam int pixel_count = reduced_width * reduced_height;
    localparam int w           = reduced_width;

    // Every pixel written since reset, frames laid end to end
    int pixels [$];

    edge_class_t expected;
    int          last_needed;

    initial begin
        written    = 0;
        popped     = 0;
        mismatches = 0;
    end

    // Neighbours outside the current frame count as zero
    function automatic int pixel_at(input int base, input int index);
        if (index < 0 || index >= pixel_count) begin
            return 0;
        end
        return pixels[base+index];
    endfunction

    function automatic edge_class_t expected_class(input int position);
        int base;
        int k;
        int best;
        int centre;
        int kept;
        int x;
        int y;
        int d;
        int j;
        int sums [4];
        int strict_off [4];
        int loose_off [4];
        base = position - position % pixel_count;
        k    = position % pixel_count;
        // Direction order north_south, east_west, north_west, north_east
        sums[0] = pixel_at(base, k - w) + pixel_at(base, k + w);
        sums[1] = pixel_at(base, k - 1) + pixel_at(base, k + 1);
        sums[2] = pixel_at(base, k - w - 1) + pixel_at(base, k + w + 1);
        sums[3] = pixel_at(base, k - w + 1) + pixel_at(base, k + w - 1);
        strict_off = '{-1, -w, -w + 1, -w - 1};
        loose_off  = '{1, w, w - 1, w + 1};
        // First direction that no later direction beats
        best = -1;
        for (d = 0; d < 4; d++) begin
            if (best < 0) begin
                best = d;
                for (j = d + 1; j < 4; j++) begin
                    if (sums[j] > sums[d]) begin
                        best = -1;
                    end
                end
            end
        end
        centre = pixel_at(base, k);
        kept   = 0;
        if (centre > pixel_at(base, k + strict_off[best]) &&
            centre >= pixel_at(base, k + loose_off[best])) begin
            kept = centre;
        end
        x = k % w + starting_x;
        y = k / w + starting_y;
        if (x == 0 || x == width - 1 || y == 0 || y == height - 1) begin
            kept = 0;
        end
        if (kept >= high_threshold) begin
            return edge_strong;
        end else if (kept >= low_threshold) begin
            return edge_weak;
        end
        return edge_none;
    endfunction

    always @(posedge clock) begin
        if (!reset) begin
            if (in_wr_en) begin
                pixels.push_back(int'(in_din));
                written++;
            end
            if (out_rd_en) begin
                // The last pixel the window of this output depends on
                last_needed = popped - popped % pixel_count +
                              ((popped % pixel_count + w + 1 < pixel_count) ?
                               popped % pixel_count + w + 1 : pixel_count - 1);
                if (last_needed >= pixels.size()) begin
                    $display("checker: output word %0d came out before its input pixels",
                             popped);
                    mismatches++;
                end else begin
                    expected = expected_class(popped);
                    if (out_dout !== expected) begin
                        $display("FAIL %0t: frame %0d pixel %0d expected %s got %s",
                                 $time, popped / pixel_count, popped % pixel_count,
                                 expected.name(), out_dout.name());
                        mismatches++;
                    end
                end
                popped++;
            end
        end
    end

endmodule

//--- edge_pkg.sv
package edge_pkg;

    // Pixel values and gradient magnitudes share one 8-bit unsigned type
    typedef logic [7:0] pixel_t;

    // Edge class after double thresholding
    typedef enum logic [1:0] {
        edge_none   = 2'd0,
        edge_weak   = 2'd1,
        edge_strong = 2'd2
    } edge_class_t;

    // Words per FIFO unless the top level asks for another depth
    localparam int fifo_depth_default = 16;

endpackage

//--- edge_stage_top.sv
module edge_stage_top
    import edge_pkg::*;
#(
    parameter int reduced_width  = 64,
    parameter int reduced_height = 48,
    parameter int width          = 80,
    parameter int height         = 60,
    parameter int starting_x     = 8,
    parameter int starting_y     = 6,
    parameter int low_threshold  = 40,
    parameter int high_threshold = 120,
    parameter int fifo_depth     = fifo_depth_default
) (
    input  logic        clock,
    input  logic        reset,
    input  logic        in_wr_en,
    input  pixel_t      in_din,
    output logic        in_full,
    input  logic        out_rd_en,
    output edge_class_t out_dout,
    output logic        out_empty
);

    // Input FIFO to suppressor
    logic   nms_rd_en;
    logic   nms_empty;
    pixel_t nms_dout;

    // Suppressor to middle FIFO
    logic   nms_wr_en;
    logic   mid_full;
    pixel_t nms_din;

    // Middle FIFO to threshold stage
    logic   thr_rd_en;
    logic   mid_empty;
    pixel_t mid_dout;

    // Threshold stage to output FIFO
    logic        thr_wr_en;
    logic        out_full;
    edge_class_t thr_din;

    fifo #(
        .payload_t (pixel_t),
        .depth     (fifo_depth)
    ) u_in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (in_wr_en),
        .din   (in_din),
        .full  (in_full),
        .rd_en (nms_rd_en),
        .dout  (nms_dout),
        .empty (nms_empty)
    );

    non_maximum_suppressor #(
        .reduced_width  (reduced_width),
        .reduced_height (reduced_height),
        .width          (width),
        .height         (height),
        .starting_x     (starting_x),
        .starting_y     (starting_y)
    ) u_non_maximum_suppressor (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (nms_rd_en),
        .in_empty  (nms_empty),
        .in_dout   (nms_dout),
        .out_wr_en (nms_wr_en),
        .out_full  (mid_full),
        .out_din   (nms_din)
    );

    fifo #(
        .payload_t (pixel_t),
        .depth     (fifo_depth)
    ) u_mid_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (nms_wr_en),
        .din   (nms_din),
        .full  (mid_full),
        .rd_en (thr_rd_en),
        .dout  (mid_dout),
        .empty (mid_empty)
    );

    edge_threshold #(
        .low_threshold  (low_threshold),
        .high_threshold (high_threshold),
        .pixel_count    (reduced_width * reduced_height)
    ) u_edge_threshold (
        .clock     (clock),
        .reset     (reset),
        .in_rd_en  (thr_rd_en),
        .in_empty  (mid_empty),
        .in_dout   (mid_dout),
        .out_wr_en (thr_wr_en),
        .out_full  (out_full),
        .out_din   (thr_din)
    );

    fifo #(
        .payload_t (edge_class_t),
        .depth     (fifo_depth)
    ) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (thr_wr_en),
        .din   (thr_din),
        .full  (out_full),
        .rd_en (out_rd_en),
        .dout  (out_dout),
        .empty (out_empty)
    );

endmodule

//--- edge_tb.sv
module edge_tb;
    import edge_pkg::*;

    localparam int reduced_width  = 8;
    localparam int reduced_height = 6;
    localparam int width          = 10;
    localparam int height         = 8;
    localparam int starting_x     = 0;
    localparam int starting_y     = 1;
    localparam int low_threshold  = 40;
    localparam int high_threshold = 120;
    // Shallow FIFOs so back-pressure reaches the input quickly
    localparam int fifo_depth     = 4;
    localparam int pixel_count    = reduced_width * reduced_height;
    localparam int wait_limit     = 2000;
    localparam logic [31:0] seed  = 32'h7d609798;

    logic        clock = 1'b0;
    logic        reset;
    logic        in_wr_en;
    pixel_t      in_din;
    logic        in_full;
    logic        out_rd_en;
    edge_class_t out_dout;
    logic        out_empty;

    int written;
    int popped;
    int mismatches;
    int pass_count;
    int fail_count;
    logic timed_out;

    // Separate streams for pixel values, write gaps and read stalls
    logic [31:0] data_state;
    logic [31:0] gap_state;
    logic [31:0] read_state;

    edge_stage_top #(
        .reduced_width  (reduced_width),
        .reduced_height (reduced_height),
        .width          (width),
        .height         (height),
        .starting_x     (starting_x),
        .starting_y     (starting_y),
        .low_threshold  (low_threshold),
        .high_threshold (high_threshold),
        .fifo_depth     (fifo_depth)
    ) u_edge_stage_top (
        .clock     (clock),
        .reset     (reset),
        .in_wr_en  (in_wr_en),
        .in_din    (in_din),
        .in_full   (in_full),
        .out_rd_en (out_rd_en),
        .out_dout  (out_dout),
        .out_empty (out_empty)
    );

    edge_checker #(
        .reduced_width  (reduced_width),
        .reduced_height (reduced_height),
        .width          (width),
        .height         (height),
        .starting_x     (starting_x),
        .starting_y     (starting_y),
        .low_threshold  (low_threshold),
        .high_threshold (high_threshold)
    ) u_edge_checker (
        .clock      (clock),
        .reset      (reset),
        .in_wr_en   (in_wr_en),
        .in_din     (in_din),
        .out_rd_en  (out_rd_en),
        .out_dout   (out_dout),
        .written    (written),
        .popped     (popped),
        .mismatches (mismatches)
    );

    always #4 clock = ~clock;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic report_timeout(input string what);
        $display("timeout: no %s within %0d cycles", what, wait_limit);
        timed_out = 1'b1;
    endtask

    task automatic write_pixels(input int count, input int gap_percent, input int max_value);
        int sent;
        int idle;
        sent = 0;
        idle = 0;
        while (sent < count && !timed_out) begin
            @(posedge clock);
            #1;
            gap_state = lcg_next(gap_state);
            if (!in_full && int'(gap_state[31:16]) % 100 >= gap_percent) begin
                data_state = lcg_next(data_state);
                in_wr_en   = 1'b1;
                // Levels spread over the full pixel range so they reach the thresholds
                in_din     = pixel_t'((int'(data_state[31:16]) % (max_value + 1)) *
                                      (255 / max_value));
                sent++;
                idle = 0;
            end else begin
                in_wr_en = 1'b0;
                idle++;
                if (idle > wait_limit) begin
                    report_timeout("space in the input FIFO");
                end
            end
        end
        @(posedge clock);
        #1;
        in_wr_en = 1'b0;
    endtask

    task automatic read_outputs(input int count, input int stall_percent);
        int got;
        int idle;
        got  = 0;
        idle = 0;
        while (got < count && !timed_out) begin
            @(posedge clock);
            #1;
            read_state = lcg_next(read_state);
            if (!out_empty && int'(read_state[31:16]) % 100 >= stall_percent) begin
                out_rd_en = 1'b1;
                got++;
                idle = 0;
            end else begin
                out_rd_en = 1'b0;
                idle++;
                if (idle > wait_limit) begin
                    report_timeout("word in the output FIFO");
                end
            end
        end
        @(posedge clock);
        #1;
        out_rd_en = 1'b0;
    endtask

    task automatic run_test(input int number, input string name, input int frames,
                            input int gap_percent, input int stall_percent,
                            input int max_value);
        int errors_before;
        int cycle;
        logic extra;
        errors_before = mismatches;
        extra         = 1'b0;
        fork
            write_pixels(frames * pixel_count, gap_percent, max_value);
            read_outputs(frames * pixel_count, stall_percent);
        join
        // Nothing more may come out once every pixel has its class
        for (cycle = 0; cycle < 20; cycle++) begin
            @(posedge clock);
            #1;
            if (!out_empty) begin
                extra = 1'b1;
            end
        end
        if (extra) begin
            $display("test %0d: output FIFO holds words beyond the pixel count", number);
        end
        if (!timed_out && !extra && mismatches == errors_before) begin
            pass_count++;
            $display("test %0d %s: passed", number, name);
        end else begin
            fail_count++;
            $display("test %0d %s: failed", number, name);
        end
    endtask

    initial begin
        reset      = 1'b1;
        in_wr_en   = 1'b0;
        in_din     = '0;
        out_rd_en  = 1'b0;
        timed_out  = 1'b0;
        pass_count = 0;
        fail_count = 0;
        data_state = seed;
        gap_state  = lcg_next(seed);
        read_state = lcg_next(gap_state);
        repeat (3) @(posedge clock);
        #1;
        reset = 1'b0;

        run_test(1, "continuous stream", 1, 0, 0, 255);
        if (!timed_out) run_test(2, "input gaps", 1, 40, 0, 255);
        if (!timed_out) run_test(3, "output back-pressure", 1, 0, 75, 255);
        if (!timed_out) run_test(4, "two frames back to back", 2, 0, 0, 255);
        if (!timed_out) run_test(5, "four levels and ties", 1, 0, 0, 3);

        $display("summary: %0d passed, %0d failed, %0d pixels written, %0d classes read",
                 pass_count, fail_count, written, popped);
        if (fail_count == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

//--- edge_threshold.sv
module edge_threshold
    import edge_pkg::*;
#(
    parameter int low_threshold  = 40,
    parameter int high_threshold = 120,
    parameter int pixel_count    = 64 * 48
) (
    input  logic        clock,
    input  logic        reset,
    output logic        in_rd_en,
    input  logic        in_empty,
    input  pixel_t      in_dout,
    output logic        out_wr_en,
    input  logic        out_full,
    output edge_class_t out_din
);

    logic transfer;
    logic is_strong;

    // One word per cycle straight from the input head
    assign transfer  = !in_empty && !out_full;
    assign in_rd_en  = transfer;
    assign out_wr_en = transfer;

    assign is_strong = (in_dout >= pixel_t'(high_threshold));

    always_comb begin
        if (is_strong) begin
            out_din = edge_strong;
        end else if (in_dout >= pixel_t'(low_threshold)) begin
            out_din = edge_weak;
        end else begin
            out_din = edge_none;
        end
    end

endmodule

//--- fifo.sv
module fifo
    import edge_pkg::*;
#(
    parameter type payload_t = pixel_t,
    parameter int  depth     = fifo_depth_default
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    output logic     full,
    input  logic     rd_en,
    output payload_t dout,
    output logic     empty
);

    localparam int ptr_bits   = (depth > 1) ? $clog2(depth) : 1;
    localparam int count_bits = $clog2(depth + 1);

    payload_t             mem [depth];
    logic [ptr_bits-1:0]  wr_ptr;
    logic [ptr_bits-1:0]  rd_ptr;
    logic [count_bits-1:0] count;

    // First-word fall-through, the head is always on dout
    assign dout  = mem[rd_ptr];
    assign empty = (count == '0);
    assign full  = (count == count_bits'(depth));

    always_ff @(posedge clock) begin
        if (wr_en) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // Simultaneous push and pop leaves the level unchanged
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Writers and readers must respect the flags
    assert property (@(posedge clock) disable iff (reset) !(wr_en && full))
        else $error("fifo write while full");

    assert property (@(posedge clock) disable iff (reset) !(rd_en && empty))
        else $error("fifo read while empty");

endmodule

//--- non_maximum_suppressor.sv
module non_maximum_suppressor
    import edge_pkg::*;
#(
    parameter int reduced_width  = 64,
    parameter int reduced_height = 48,
    parameter int width          = 80,
    parameter int height         = 60,
    parameter int starting_x     = 8,
    parameter int starting_y     = 6
) (
    input  logic   clock,
    input  logic   reset,
    output logic   in_rd_en,
    input  logic   in_empty,
    input  pixel_t in_dout,
    output logic   out_wr_en,
    input  logic   out_full,
    output pixel_t out_din
);

    localparam int shift_len   = 2 * reduced_width + 3;
    localparam int pixel_count = reduced_width * reduced_height;
    localparam int fill_bits   = $clog2(reduced_width + 3);
    localparam int read_bits   = $clog2(pixel_count + 1);
    localparam int col_bits    = $clog2(reduced_width + 1);
    localparam int row_bits    = $clog2(reduced_height + 1);
    localparam int x_bits      = $clog2(width + 1);
    localparam int y_bits      = $clog2(height + 1);

    typedef enum logic [1:0] {
        state_prologue,
        state_suppression,
        state_output
    } state_t;

    state_t state, state_next;

    // Index 0 holds the oldest pixel, new pixels enter at the far end
    pixel_t [0:shift_len-1] shift_reg;
    pixel_t [0:shift_len-1] shift_reg_next;

    logic [fill_bits-1:0] fill_count, fill_count_next;
    logic [read_bits-1:0] read_count, read_count_next;
    logic [col_bits-1:0]  col, col_next;
    logic [row_bits-1:0]  row, row_next;

    pixel_t result, result_next;

    // 3x3 window around the centre pixel p5
    pixel_t p1, p2, p3, p4, p5, p6, p7, p8, p9;
    logic [8:0] north_south, east_west, north_west, north_east;

    logic [x_bits-1:0] frame_x;
    logic [y_bits-1:0] frame_y;
    logic   on_border;
    logic   padding;
    logic   last_pixel;
    pixel_t new_pixel;
    pixel_t nms_value;

    assign p1 = shift_reg[0];
    assign p2 = shift_reg[1];
    assign p3 = shift_reg[2];
    assign p4 = shift_reg[reduced_width];
    assign p5 = shift_reg[reduced_width+1];
    assign p6 = shift_reg[reduced_width+2];
    assign p7 = shift_reg[2*reduced_width];
    assign p8 = shift_reg[2*reduced_width+1];
    assign p9 = shift_reg[2*reduced_width+2];

    // Nine bits so the sums cannot overflow
    assign north_south = {1'b0, p2} + {1'b0, p8};
    assign east_west   = {1'b0, p4} + {1'b0, p6};
    assign north_west  = {1'b0, p1} + {1'b0, p9};
    assign north_east  = {1'b0, p3} + {1'b0, p7};

    // Position of the centre pixel in the full frame
    assign frame_x = x_bits'(col) + x_bits'(starting_x);
    assign frame_y = y_bits'(row) + y_bits'(starting_y);

    assign on_border = (frame_x == '0) || (frame_x == x_bits'(width - 1)) ||
                       (frame_y == '0) || (frame_y == y_bits'(height - 1));

    // All pixels of the frame consumed, feed zeros from here on
    assign padding   = (read_count == read_bits'(pixel_count));
    assign new_pixel = padding ? '0 : in_dout;

    assign last_pixel = (col == col_bits'(reduced_width - 1)) &&
                        (row == row_bits'(reduced_height - 1));

    // Tie order is north_south, east_west, north_west, north_east
    always_comb begin
        nms_value = '0;
        if (north_south >= east_west && north_south >= north_west &&
            north_south >= north_east) begin
            if (p5 > p4 && p5 >= p6) begin
                nms_value = p5;
            end
        end else if (east_west >= north_west && east_west >= north_east) begin
            if (p5 > p2 && p5 >= p8) begin
                nms_value = p5;
            end
        end else if (north_west >= north_east) begin
            if (p5 > p3 && p5 >= p7) begin
                nms_value = p5;
            end
        end else begin
            if (p5 > p1 && p5 >= p9) begin
                nms_value = p5;
            end
        end
    end

    always_comb begin
        state_next      = state;
        shift_reg_next  = shift_reg;
        fill_count_next = fill_count;
        read_count_next = read_count;
        col_next        = col;
        row_next        = row;
        result_next     = result;
        in_rd_en        = 1'b0;
        out_wr_en       = 1'b0;

        case (state)
            state_prologue: begin
                // Fill the window until the first centre pixel reaches p5
                if (!in_empty) begin
                    in_rd_en        = 1'b1;
                    shift_reg_next  = {shift_reg[1:shift_len-1], in_dout};
                    fill_count_next = fill_count + 1'b1;
                    read_count_next = read_count + 1'b1;
                    if (fill_count == fill_bits'(reduced_width + 1)) begin
                        state_next = state_suppression;
                    end
                end
            end

            state_suppression: begin
                if (padding || !in_empty) begin
                    shift_reg_next = {shift_reg[1:shift_len-1], new_pixel};
                    if (!padding) begin
                        in_rd_en        = 1'b1;
                        read_count_next = read_count + 1'b1;
                    end
                    result_next = on_border ? '0 : nms_value;
                    state_next  = state_output;
                end
            end

            state_output: begin
                if (!out_full) begin
                    out_wr_en = 1'b1;
                    if (last_pixel) begin
                        // Frame done, start clean for the next one
                        state_next      = state_prologue;
                        shift_reg_next  = '0;
                        fill_count_next = '0;
                        read_count_next = '0;
                        col_next        = '0;
                        row_next        = '0;
                    end else begin
                        state_next = state_suppression;
                        if (col == col_bits'(reduced_width - 1)) begin
                            col_next = '0;
                            row_next = row + 1'b1;
                        end else begin
                            col_next = col + 1'b1;
                        end
                    end
                end
            end

            default: begin
                state_next = state_prologue;
            end
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state      <= state_prologue;
            shift_reg  <= '0;
            fill_count <= '0;
            read_count <= '0;
            col        <= '0;
            row        <= '0;
            result     <= '0;
        end else begin
            state      <= state_next;
            shift_reg  <= shift_reg_next;
            fill_count <= fill_count_next;
            read_count <= read_count_next;
            col        <= col_next;
            row        <= row_next;
            result     <= result_next;
        end
    end

    assign out_din = result;

endmodule

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module edge_tb -o edge_sim

./obj_dir/edge_sim > sim.log 2>&1
cat sim.log

if grep -q "all tests passed" sim.log; then
    exit 0
fi
exit 1
